// ==== verilog.f ====
+incdir+logic
logic/rvv_mask_pkg.sv
logic/rvv_mask_operand_if.sv
logic/rvv_mask_src_prep.sv
logic/rvv_mask_logic_ops.sv
logic/rvv_mask_scan_ops.sv
logic/rvv_mask_iota_id.sv
logic/rvv_mask_writeback.sv
logic/rvv_mask_unit.sv
testbench/tb_rvv_mask_unit.sv

// ==== Makefile ====
TOP = tb_rvv_mask_unit

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	verilator --binary -Wno-fatal -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== testbench/tb_rvv_mask_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvv_mask_defs.svh"

module tb_rvv_mask_unit import rvv_mask_pkg::*;;

  localparam int NUM_UOPS    = 600;
  localparam int CYCLE_LIMIT = NUM_UOPS + 50;

  logic                          clk;
  logic                          rst_n;
  logic                          uop_valid;
  mask_op_e                      op;
  eew_e                          eew;
  logic [`ROB_DEPTH_WIDTH-1:0]   rob_entry;
  logic [`VL_WIDTH-1:0]          vl;
  logic [`VSTART_WIDTH-1:0]      vstart;
  logic                          vm;
  logic [`UOP_INDEX_WIDTH-1:0]   uop_index;
  logic [`VLEN-1:0]              vs1_data;
  logic                          vs1_valid;
  logic [`VLEN-1:0]              vs2_data;
  logic                          vs2_valid;
  logic [`VLEN-1:0]              vd_data;
  logic                          vd_valid;
  logic [`VLEN-1:0]              v0_data;
  logic                          v0_valid;
  logic                          result_valid;
  logic [`ROB_DEPTH_WIDTH-1:0]   result_rob_entry;
  logic [`VLEN-1:0]              result_data;

  logic [31:0]                   lcg_state;
  int                            errors;
  int                            checks;
  int                            cycle_count = 0;

  // one expectation per driven cycle
  logic                          exp_valid_q[$];
  logic [`ROB_DEPTH_WIDTH-1:0]   exp_rob_q[$];
  logic [`VLEN-1:0]              exp_data_q[$];
  mask_op_e                      exp_op_q[$];

  rvv_mask_unit dut_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .uop_valid        (uop_valid),
    .op               (op),
    .eew              (eew),
    .rob_entry        (rob_entry),
    .vl               (vl),
    .vstart           (vstart),
    .vm               (vm),
    .uop_index        (uop_index),
    .vs1_data         (vs1_data),
    .vs1_valid        (vs1_valid),
    .vs2_data         (vs2_data),
    .vs2_valid        (vs2_valid),
    .vd_data          (vd_data),
    .vd_valid         (vd_valid),
    .v0_data          (v0_data),
    .v0_valid         (v0_valid),
    .result_valid     (result_valid),
    .result_rob_entry (result_rob_entry),
    .result_data      (result_data)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // upper bits only since the low ones cycle quickly
  function automatic int rand_below(int n);
    return int'(lcg_next() >> 16) % n;
  endfunction

  function automatic logic [63:0] rand64();
    logic [63:0] v;
    logic [31:0] r;
    v = '0;
    for (int i = 0; i < 4; i++) begin
      r = lcg_next();
      v = {v[47:0], r[31:16]};
    end
    return v;
  endfunction

  function automatic logic model_ready();
    case (op)
      OP_CPOP, OP_FIRST, OP_IOTA: return vs2_valid && (vm || v0_valid);
      OP_MSBF, OP_MSIF, OP_MSOF: return vs2_valid && (vm || (vd_valid && v0_valid));
      OP_ID: return 1'b1;
      default: return vs1_valid && vs2_valid && vd_valid && vm;
    endcase
  endfunction

  function automatic logic [63:0] model_data();
    logic [63:0] res;
    logic [63:0] keep;
    logic [63:0] low;
    int          cnt;
    int          first;
    int          ew;
    int          per_reg;
    int          elem;
    int          val;
    res   = '0;
    keep  = '0;
    cnt   = 0;
    first = -1;
    for (int i = 0; i < 64; i++) begin
      low[i] = i < vstart;
      if (vs2_data[i] && (i < vl) && (vm || v0_data[i])) begin
        cnt++;
        if (first < 0) begin
          first = i;
        end
      end
    end
    case (op)
      OP_MANDN: res = vs2_data & ~vs1_data;
      OP_MAND:  res = vs2_data & vs1_data;
      OP_MOR:   res = vs2_data | vs1_data;
      OP_MXOR:  res = vs2_data ^ vs1_data;
      OP_MORN:  res = vs2_data | ~vs1_data;
      OP_MNAND: res = ~(vs2_data & vs1_data);
      OP_MNOR:  res = ~(vs2_data | vs1_data);
      OP_MXNOR: res = ~(vs2_data ^ vs1_data);
      OP_CPOP:  res = 64'(cnt);
      OP_FIRST: res = (first < 0) ? '1 : 64'(first);
      OP_MSBF, OP_MSIF, OP_MSOF: begin
        for (int i = 0; i < 64; i++) begin
          if (first < 0) begin
            res[i] = 1'b1;
          end else if (op == OP_MSBF) begin
            res[i] = i < first;
          end else if (op == OP_MSIF) begin
            res[i] = i <= first;
          end else begin
            res[i] = i == first;
          end
          // masked-off body elements take old vd
          if (!vm) begin
            keep[i] = (i < vl) && !v0_data[i];
          end
        end
      end
      default: begin
        ew      = (eew == EEW8) ? 8 : ((eew == EEW16) ? 16 : 32);
        per_reg = 64 / ew;
        for (int k = 0; k < per_reg; k++) begin
          elem = uop_index * per_reg + k;
          val  = elem;
          if (op == OP_IOTA) begin
            val = 0;
            for (int j = 0; j < elem; j++) begin
              if (vs2_data[j] && (vm || v0_data[j])) begin
                val++;
              end
            end
          end
          for (int b = 0; b < ew; b++) begin
            res[k*ew+b] = val[b];
          end
        end
      end
    endcase
    if (op inside {OP_MANDN, OP_MAND, OP_MOR, OP_MXOR,
                   OP_MORN, OP_MNAND, OP_MNOR, OP_MXNOR}) begin
      keep = low;
    end
    return (res & ~keep) | (vd_data & keep);
  endfunction

  task automatic drive_uop();
    uop_valid = rand_below(100) < 80;
    op        = mask_op_e'(rand_below(15));
    eew       = eew_e'(rand_below(3));
    rob_entry = 4'(rand_below(16));
    vl        = 7'(rand_below(65));
    vstart    = 6'(rand_below(64));
    vm        = rand_below(2) == 1;
    uop_index = 3'(rand_below(8));
    vs1_data  = rand64();
    vd_data   = rand64();
    v0_data   = rand64();
    // zero and sparse sources reach the no-first-one cases
    case (rand_below(8))
      0:       vs2_data = '0;
      1:       vs2_data = rand64() & rand64() & rand64();
      default: vs2_data = rand64();
    endcase
    vs1_valid = rand_below(100) < 80;
    vs2_valid = rand_below(100) < 80;
    vd_valid  = rand_below(100) < 80;
    v0_valid  = rand_below(100) < 80;
    exp_valid_q.push_back(uop_valid && model_ready());
    exp_rob_q.push_back(rob_entry);
    exp_data_q.push_back(model_data());
    exp_op_q.push_back(op);
  endtask

  task automatic check_result();
    logic                        exp_v;
    logic [`ROB_DEPTH_WIDTH-1:0] exp_rob;
    logic [`VLEN-1:0]            exp_d;
    mask_op_e                    exp_op;
    exp_v   = exp_valid_q.pop_front();
    exp_rob = exp_rob_q.pop_front();
    exp_d   = exp_data_q.pop_front();
    exp_op  = exp_op_q.pop_front();
    checks++;
    if (result_valid !== exp_v) begin
      $display("Error: result_valid expected %h got %h, op %s",
               exp_v, result_valid, exp_op.name());
      errors++;
    end else if (exp_v) begin
      checks++;
      if (result_rob_entry !== exp_rob) begin
        $display("Error: result_rob_entry expected %h got %h, op %s",
                 exp_rob, result_rob_entry, exp_op.name());
        errors++;
      end
      if (result_data !== exp_d) begin
        $display("Error: result_data expected %h got %h, op %s",
                 exp_d, result_data, exp_op.name());
        errors++;
      end
    end
  endtask

  initial begin
    lcg_state = 32'd45;
    errors    = 0;
    checks    = 0;
    clk       = 1'b0;
    rst_n     = 1'b0;
    // a valid id uop during reset must not reach the outputs
    uop_valid = 1'b1;
    op        = OP_ID;
    eew       = EEW8;
    rob_entry = 4'hf;
    vl        = '0;
    vstart    = '0;
    vm        = 1'b1;
    uop_index = 3'd1;
    vs1_data  = '0;
    vs1_valid = 1'b0;
    vs2_data  = '0;
    vs2_valid = 1'b0;
    vd_data   = '0;
    vd_valid  = 1'b0;
    v0_data   = '0;
    v0_valid  = 1'b0;

    repeat (5) @(posedge clk);
    #2 rst_n = 1'b1;

    // reset values before the first uop
    checks++;
    if (result_valid !== 1'b0) begin
      $display("Error: result_valid expected %h got %h after reset", 1'b0, result_valid);
      errors++;
    end
    if (result_rob_entry !== '0) begin
      $display("Error: result_rob_entry expected %h got %h after reset",
               4'h0, result_rob_entry);
      errors++;
    end
    if (result_data !== '0) begin
      $display("Error: result_data expected %h got %h after reset",
               64'h0, result_data);
      errors++;
    end

    for (int n = 0; n < NUM_UOPS; n++) begin
      drive_uop();
      @(posedge clk);
      #2;
      check_result();
    end
    uop_valid = 1'b0;

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/rvv_mask_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvv_mask_defs.svh"

module rvv_mask_unit import rvv_mask_pkg::*; (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          uop_valid,
  input  mask_op_e                      op,
  input  eew_e                          eew,
  input  logic [`ROB_DEPTH_WIDTH-1:0]   rob_entry,
  input  logic [`VL_WIDTH-1:0]          vl,
  input  logic [`VSTART_WIDTH-1:0]      vstart,
  input  logic                          vm,
  input  logic [`UOP_INDEX_WIDTH-1:0]   uop_index,
  input  logic [`VLEN-1:0]              vs1_data,
  input  logic                          vs1_valid,
  input  logic [`VLEN-1:0]              vs2_data,
  input  logic                          vs2_valid,
  input  logic [`VLEN-1:0]              vd_data,
  input  logic                          vd_valid,
  input  logic [`VLEN-1:0]              v0_data,
  input  logic                          v0_valid,
  output logic                          result_valid,
  output logic [`ROB_DEPTH_WIDTH-1:0]   result_rob_entry,
  output logic [`VLEN-1:0]              result_data
);

  logic [`VLEN-1:0]       and_res;
  logic [`VLEN-1:0]       andn_res;
  logic [`VLEN-1:0]       or_res;
  logic [`VLEN-1:0]       xor_res;
  logic [`VLEN-1:0]       orn_res;
  logic [`VLEN-1:0]       nand_res;
  logic [`VLEN-1:0]       nor_res;
  logic [`VLEN-1:0]       xnor_res;
  logic [`VLEN-1:0]       msbf_res;
  logic [`VLEN-1:0]       msif_res;
  logic [`VLEN-1:0]       msof_res;
  logic [`VLEN-1:0]       first_res;
  logic [`CPOP_WIDTH-1:0] cpop_res;
  logic [`VLEN-1:0]       iota_res;
  logic [`VLEN-1:0]       id_res;

  rvv_mask_operand_if opnd_if ();

  rvv_mask_src_prep src_prep_i (
    .op        (op),
    .vl        (vl),
    .vstart    (vstart),
    .vm        (vm),
    .uop_valid (uop_valid),
    .vs1_data  (vs1_data),
    .vs1_valid (vs1_valid),
    .vs2_data  (vs2_data),
    .vs2_valid (vs2_valid),
    .vd_valid  (vd_valid),
    .v0_data   (v0_data),
    .v0_valid  (v0_valid),
    .opnd      (opnd_if.prep)
  );

  rvv_mask_logic_ops logic_ops_i (
    .opnd     (opnd_if.compute),
    .and_res  (and_res),
    .andn_res (andn_res),
    .or_res   (or_res),
    .xor_res  (xor_res),
    .orn_res  (orn_res),
    .nand_res (nand_res),
    .nor_res  (nor_res),
    .xnor_res (xnor_res)
  );

  rvv_mask_scan_ops scan_ops_i (
    .opnd      (opnd_if.compute),
    .msbf_res  (msbf_res),
    .msif_res  (msif_res),
    .msof_res  (msof_res),
    .first_res (first_res),
    .cpop_res  (cpop_res)
  );

  rvv_mask_iota_id iota_id_i (
    .opnd      (opnd_if.compute),
    .eew       (eew),
    .uop_index (uop_index),
    .iota_res  (iota_res),
    .id_res    (id_res)
  );

  rvv_mask_writeback writeback_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .op               (op),
    .rob_entry        (rob_entry),
    .vd_data          (vd_data),
    .opnd             (opnd_if.wb),
    .and_res          (and_res),
    .andn_res         (andn_res),
    .or_res           (or_res),
    .xor_res          (xor_res),
    .orn_res          (orn_res),
    .nand_res         (nand_res),
    .nor_res          (nor_res),
    .xnor_res         (xnor_res),
    .msbf_res         (msbf_res),
    .msif_res         (msif_res),
    .msof_res         (msof_res),
    .first_res        (first_res),
    .cpop_res         (cpop_res),
    .iota_res         (iota_res),
    .id_res           (id_res),
    .result_valid     (result_valid),
    .result_rob_entry (result_rob_entry),
    .result_data      (result_data)
  );

endmodule

`default_nettype wire

// ==== logic/rvv_mask_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvv_mask_defs.svh"

module rvv_mask_writeback import rvv_mask_pkg::*; (
  input  logic                          clk,
  input  logic                          rst_n,
  input  mask_op_e                      op,
  input  logic [`ROB_DEPTH_WIDTH-1:0]   rob_entry,
  input  logic [`VLEN-1:0]              vd_data,
  rvv_mask_operand_if.wb                opnd,
  input  logic [`VLEN-1:0]              and_res,
  input  logic [`VLEN-1:0]              andn_res,
  input  logic [`VLEN-1:0]              or_res,
  input  logic [`VLEN-1:0]              xor_res,
  input  logic [`VLEN-1:0]              orn_res,
  input  logic [`VLEN-1:0]              nand_res,
  input  logic [`VLEN-1:0]              nor_res,
  input  logic [`VLEN-1:0]              xnor_res,
  input  logic [`VLEN-1:0]              msbf_res,
  input  logic [`VLEN-1:0]              msif_res,
  input  logic [`VLEN-1:0]              msof_res,
  input  logic [`VLEN-1:0]              first_res,
  input  logic [`CPOP_WIDTH-1:0]        cpop_res,
  input  logic [`VLEN-1:0]              iota_res,
  input  logic [`VLEN-1:0]              id_res,
  output logic                          result_valid,
  output logic [`ROB_DEPTH_WIDTH-1:0]   result_rob_entry,
  output logic [`VLEN-1:0]              result_data
);

  logic [`VLEN-1:0] sel_res;
  logic [`VLEN-1:0] merged;

  always_comb begin
    case (op)
      OP_MANDN: sel_res = andn_res;
      OP_MAND:  sel_res = and_res;
      OP_MOR:   sel_res = or_res;
      OP_MXOR:  sel_res = xor_res;
      OP_MORN:  sel_res = orn_res;
      OP_MNAND: sel_res = nand_res;
      OP_MNOR:  sel_res = nor_res;
      OP_MXNOR: sel_res = xnor_res;
      OP_CPOP:  sel_res = `VLEN'(cpop_res);
      OP_FIRST: sel_res = first_res;
      OP_MSBF:  sel_res = msbf_res;
      OP_MSIF:  sel_res = msif_res;
      OP_MSOF:  sel_res = msof_res;
      OP_IOTA:  sel_res = iota_res;
      OP_ID:    sel_res = id_res;
      default:  sel_res = '0;
    endcase
  end

  // old vd where keep_vd is set
  assign merged = (sel_res & ~opnd.keep_vd) | (vd_data & opnd.keep_vd);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_valid     <= 1'b0;
      result_rob_entry <= '0;
      result_data      <= '0;
    end else begin
      result_valid <= opnd.fire;
      if (opnd.fire) begin
        result_rob_entry <= rob_entry;
        result_data      <= merged;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/rvv_mask_iota_id.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvv_mask_defs.svh"

module rvv_mask_iota_id import rvv_mask_pkg::*; (
  rvv_mask_operand_if.compute           opnd,
  input  eew_e                          eew,
  input  logic [`UOP_INDEX_WIDTH-1:0]   uop_index,
  output logic [`VLEN-1:0]              iota_res,
  output logic [`VLEN-1:0]              id_res
);

  // exclusive count of set bits below each position within its byte
  logic [`VLEN-1:0][3:0]              in_byte;
  logic [`VLENB-1:0][3:0]             byte_tot;
  logic [`VLENB-1:0][`IOTA_WIDTH-1:0] byte_base;
  logic [`VLEN-1:0][`IOTA_WIDTH-1:0]  prefix;
  logic [`IOTA_WIDTH-1:0]             idx;

  always_comb begin
    for (int j = 0; j < `VLENB; j++) begin
      byte_tot[j] = '0;
      for (int b = 0; b < 8; b++) begin
        in_byte[8*j+b] = byte_tot[j];
        byte_tot[j]    = byte_tot[j] + 4'(opnd.iota_src[8*j+b]);
      end
    end
  end

  // carry from the preceding bytes
  always_comb begin
    byte_base[0] = '0;
    for (int j = 1; j < `VLENB; j++) begin
      byte_base[j] = byte_base[j-1] + `IOTA_WIDTH'(byte_tot[j-1]);
    end
  end

  always_comb begin
    for (int i = 0; i < `VLEN; i++) begin
      prefix[i] = byte_base[i/8] + `IOTA_WIDTH'(in_byte[i]);
    end
  end

  // element k of this uop is element uop_index*count + k of the group
  always_comb begin
    iota_res = '0;
    id_res   = '0;
    idx      = '0;
    case (eew)
      EEW8: begin
        for (int k = 0; k < `VLENB; k++) begin
          idx               = `IOTA_WIDTH'(uop_index * `VLENB + k);
          iota_res[8*k +: 8] = 8'(prefix[idx]);
          id_res[8*k +: 8]   = 8'(idx);
        end
      end
      EEW16: begin
        for (int k = 0; k < `VLENB/2; k++) begin
          idx                 = `IOTA_WIDTH'(uop_index * (`VLENB/2) + k);
          iota_res[16*k +: 16] = 16'(prefix[idx]);
          id_res[16*k +: 16]   = 16'(idx);
        end
      end
      EEW32: begin
        for (int k = 0; k < `VLENB/4; k++) begin
          idx                 = `IOTA_WIDTH'(uop_index * (`VLENB/4) + k);
          iota_res[32*k +: 32] = 32'(prefix[idx]);
          id_res[32*k +: 32]   = 32'(idx);
        end
      end
      default: begin
        iota_res = '0;
        id_res   = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/rvv_mask_scan_ops.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvv_mask_defs.svh"

module rvv_mask_scan_ops (
  rvv_mask_operand_if.compute      opnd,
  output logic [`VLEN-1:0]         msbf_res,
  output logic [`VLEN-1:0]         msif_res,
  output logic [`VLEN-1:0]         msof_res,
  output logic [`VLEN-1:0]         first_res,
  output logic [`CPOP_WIDTH-1:0]   cpop_res
);

  logic [`VLEN-1:0]          first1;
  logic                      src_zero;
  logic [`VLEN/16-1:0][4:0]  grp_cnt;

  // lowest set bit as a one-hot vector
  assign first1   = opnd.src2 & (~opnd.src2 + 1'b1);
  assign src_zero = opnd.src2 == '0;

  assign msof_res = src_zero ? {`VLEN{1'b1}} : first1;
  assign msbf_res = src_zero ? {`VLEN{1'b1}} : (first1 - 1'b1);
  assign msif_res = src_zero ? {`VLEN{1'b1}} : ((first1 - 1'b1) | first1);

  // one-hot to index
  always_comb begin
    first_res = '0;
    if (src_zero) begin
      first_res = {`VLEN{1'b1}};
    end else begin
      for (int i = 0; i < `VLEN; i++) begin
        if (first1[i]) begin
          first_res = `VLEN'(i);
        end
      end
    end
  end

  // popcount per 16-bit group, then sum the groups
  always_comb begin
    for (int g = 0; g < `VLEN/16; g++) begin
      grp_cnt[g] = '0;
      for (int b = 0; b < 16; b++) begin
        grp_cnt[g] = grp_cnt[g] + 5'(opnd.src2[16*g+b]);
      end
    end
  end

  always_comb begin
    cpop_res = '0;
    for (int g = 0; g < `VLEN/16; g++) begin
      cpop_res = cpop_res + `CPOP_WIDTH'(grp_cnt[g]);
    end
  end

endmodule

`default_nettype wire

// ==== logic/rvv_mask_logic_ops.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvv_mask_defs.svh"

module rvv_mask_logic_ops (
  rvv_mask_operand_if.compute  opnd,
  output logic [`VLEN-1:0]     and_res,
  output logic [`VLEN-1:0]     andn_res,
  output logic [`VLEN-1:0]     or_res,
  output logic [`VLEN-1:0]     xor_res,
  output logic [`VLEN-1:0]     orn_res,
  output logic [`VLEN-1:0]     nand_res,
  output logic [`VLEN-1:0]     nor_res,
  output logic [`VLEN-1:0]     xnor_res
);

  // every vs2 op vs1 result computed each cycle
  assign and_res  = opnd.src2 & opnd.src1;
  assign andn_res = opnd.src2 & ~opnd.src1;
  assign or_res   = opnd.src2 | opnd.src1;
  assign xor_res  = opnd.src2 ^ opnd.src1;
  assign orn_res  = opnd.src2 | ~opnd.src1;

  assign nand_res = ~(opnd.src2 & opnd.src1);
  assign nor_res  = ~(opnd.src2 | opnd.src1);
  assign xnor_res = ~(opnd.src2 ^ opnd.src1);

endmodule

`default_nettype wire

// ==== logic/rvv_mask_src_prep.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvv_mask_defs.svh"

module rvv_mask_src_prep import rvv_mask_pkg::*; (
  input  mask_op_e                   op,
  input  logic [`VL_WIDTH-1:0]       vl,
  input  logic [`VSTART_WIDTH-1:0]   vstart,
  input  logic                       vm,
  input  logic                       uop_valid,
  input  logic [`VLEN-1:0]           vs1_data,
  input  logic                       vs1_valid,
  input  logic [`VLEN-1:0]           vs2_data,
  input  logic                       vs2_valid,
  input  logic                       vd_valid,
  input  logic [`VLEN-1:0]           v0_data,
  input  logic                       v0_valid,
  rvv_mask_operand_if.prep           opnd
);

  logic [`VLEN-1:0] tail_mask;
  logic [`VLEN-1:0] below_vstart;
  logic [`VLEN-1:0] v0_mask;
  logic             ready;

  always_comb begin
    for (int i = 0; i < `VLEN; i++) begin
      tail_mask[i]    = i < vl;
      below_vstart[i] = i < vstart;
    end
  end

  // unmasked ops see all ones here
  assign v0_mask = vm ? {`VLEN{1'b1}} : v0_data;

  always_comb begin
    opnd.src1     = '0;
    opnd.src2     = '0;
    opnd.iota_src = '0;
    opnd.keep_vd  = '0;
    ready         = 1'b0;

    case (op)
      OP_MANDN, OP_MAND, OP_MOR, OP_MXOR,
      OP_MORN, OP_MNAND, OP_MNOR, OP_MXNOR: begin
        opnd.src1    = vs1_data;
        opnd.src2    = vs2_data;
        opnd.keep_vd = below_vstart;
        ready        = vs1_valid & vs2_valid & vd_valid & vm;
      end
      OP_CPOP, OP_FIRST: begin
        opnd.src2 = vs2_data & tail_mask & v0_mask;
        ready     = vs2_valid & (vm | v0_valid);
      end
      OP_MSBF, OP_MSIF, OP_MSOF: begin
        opnd.src2    = vs2_data & tail_mask & v0_mask;
        // inactive body elements keep vd
        opnd.keep_vd = vm ? '0 : (tail_mask & ~v0_data);
        ready        = vs2_valid & (vm | (vd_valid & v0_valid));
      end
      OP_IOTA: begin
        opnd.iota_src = vs2_data & v0_mask;
        ready         = vs2_valid & (vm | v0_valid);
      end
      OP_ID: begin
        ready = 1'b1;
      end
      default: begin
        ready = 1'b0;
      end
    endcase

    opnd.fire = uop_valid & ready;
  end

endmodule

`default_nettype wire

// ==== logic/rvv_mask_operand_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvv_mask_defs.svh"

interface rvv_mask_operand_if import rvv_mask_pkg::*; ();

  logic [`VLEN-1:0] src1;
  logic [`VLEN-1:0] src2;
  logic [`VLEN-1:0] iota_src;
  // positions that keep the old vd value
  logic [`VLEN-1:0] keep_vd;
  logic             fire;

  modport prep (
    output src1, src2, iota_src, keep_vd, fire
  );

  modport compute (
    input src1, src2, iota_src
  );

  modport wb (
    input keep_vd, fire
  );

endinterface

`default_nettype wire

// ==== logic/rvv_mask_pkg.sv ====
`default_nettype none

`include "rvv_mask_defs.svh"

package rvv_mask_pkg;

  typedef enum logic [3:0] {
    OP_MANDN,
    OP_MAND,
    OP_MOR,
    OP_MXOR,
    OP_MORN,
    OP_MNAND,
    OP_MNOR,
    OP_MXNOR,
    OP_CPOP,
    OP_FIRST,
    OP_MSBF,
    OP_MSIF,
    OP_MSOF,
    OP_IOTA,
    OP_ID
  } mask_op_e;

  // destination element width for viota and vid
  typedef enum logic [1:0] {
    EEW8,
    EEW16,
    EEW32
  } eew_e;

endpackage

`default_nettype wire

// ==== logic/rvv_mask_defs.svh ====
`ifndef RVV_MASK_DEFS_SVH
`define RVV_MASK_DEFS_SVH

// vector register geometry
`define VLEN              64
`define VLENB             8

`define VL_WIDTH          7
`define VSTART_WIDTH      6
`define UOP_INDEX_WIDTH   3
`define ROB_DEPTH_WIDTH   4

// popcount of a full register reaches VLEN
`define CPOP_WIDTH        7
`define IOTA_WIDTH        6

`endif
